/* tb.f */
common/uart_frame_pkg.sv
common/wb_regs_pkg.sv
uart_rx/detect_start_bit.sv
uart_rx/rx_frame_sampler.sv
hdl/rx_fifo.sv
hdl/wb_uart_regs.sv
hdl/uart_rx_top.sv
verif/tb_clock_gen.sv
verif/uart_rx_props.sv
verif/uart_rx_tb.sv

/* Bender.yml */
package:
  name: uart_rx

sources:
  # Packages first, then the receive pipeline.
  - files:
      - common/uart_frame_pkg.sv
      - common/wb_regs_pkg.sv
      - uart_rx/detect_start_bit.sv
      - uart_rx/rx_frame_sampler.sv
      - hdl/rx_fifo.sv
      - hdl/wb_uart_regs.sv
      - hdl/uart_rx_top.sv

  # Testbench with its bound assertions, top module uart_rx_tb.
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/uart_rx_props.sv
      - verif/uart_rx_tb.sv

/* verif/uart_rx_tb.sv */
`timescale 1ns/100ps

module uart_rx_tb;
	import uart_frame_pkg::*;
	import wb_regs_pkg::*;

	localparam int drive_delay = 10; // ns after the rising edge.
	localparam int bus_timeout = 16;
	localparam int status_polls = 50;
	localparam int model_depth = 4; // Same as the DUT's FIFO.
	localparam int table_size = 12;

	typedef struct packed {
		rx_byte_t data;
		logic random_data; // Byte comes from the random generator.
		logic bad_parity;
		logic bad_stop;
		logic read_back; // Check status and drain the FIFO afterwards.
	} frame_entry_t;

	logic clk;
	logic reset;
	logic serial_in;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	wb_addr_t wb_adr;
	wb_data_t wb_dat_w;
	wb_data_t wb_dat_r;
	logic wb_ack;

	int byte_errors;
	int word_errors;
	logic [31:0] rng_state;
	rx_byte_t expected_bytes [$];
	err_count_t model_parity;
	err_count_t model_frame;
	logic model_overrun;

	// Entries without read_back run straight into the next frame.
	frame_entry_t frame_table [table_size] = '{
		'{8'h55, 1'b0, 1'b0, 1'b0, 1'b1},
		'{8'ha3, 1'b0, 1'b0, 1'b0, 1'b0},
		'{8'h00, 1'b1, 1'b0, 1'b0, 1'b0},
		'{8'hff, 1'b0, 1'b0, 1'b0, 1'b1},
		'{8'h3c, 1'b0, 1'b1, 1'b0, 1'b1}, // Parity error.
		'{8'h81, 1'b0, 1'b0, 1'b1, 1'b1}, // Framing error.
		'{8'h5a, 1'b0, 1'b1, 1'b1, 1'b1}, // Framing beats parity.
		'{8'h00, 1'b1, 1'b0, 1'b0, 1'b0}, // Five frames into four places.
		'{8'h12, 1'b0, 1'b0, 1'b0, 1'b0},
		'{8'h00, 1'b1, 1'b0, 1'b0, 1'b0},
		'{8'hc9, 1'b0, 1'b0, 1'b0, 1'b0},
		'{8'h00, 1'b1, 1'b0, 1'b0, 1'b1}
	};

	tb_clock_gen tb_clock_gen_i (.clk, .reset);

	uart_rx_top uart_rx_top_i (
		.clk, .reset, .serial_in,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
	);

	function automatic logic [31:0] next_random(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Status word as the register map describes it.
	function automatic wb_data_t expected_status();
		wb_data_t word;
		word = '0;
		word[status_empty_bit] = (expected_bytes.size() == 0);
		word[status_overrun_bit] = model_overrun;
		word[status_count_lsb +: 8] = 8'(expected_bytes.size());
		word[status_parity_lsb +: 8] = model_parity;
		word[status_frame_lsb +: 8] = model_frame;
		return word;
	endfunction

	function automatic void record_frame(input rx_byte_t data, input logic bad_parity,
			input logic bad_stop);
		if (bad_stop) begin
			model_frame++;
		end else if (bad_parity) begin
			model_parity++;
		end else if (expected_bytes.size() < model_depth) begin
			expected_bytes.push_back(data);
		end else begin
			model_overrun = 1'b1; // Full FIFO drops the byte.
		end
	endfunction

	task automatic check_byte(input rx_byte_t got, input rx_byte_t expected, input string what);
		if (got !== expected) begin
			byte_errors++;
			$display("FAIL %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, expected);
		end
	endtask

	task automatic check_word(input wb_data_t got, input wb_data_t expected, input string what);
		if (got !== expected) begin
			word_errors++;
			$display("FAIL %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, expected);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("Run stopped at %0t: %s", $time, reason);
		$display("Test FAILED");
		$finish;
	endtask

	// Tasks start and end a drive delay after a rising edge.
	task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdata,
			output wb_data_t rdata);
		int waited;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		waited = 0;
		do begin
			@(posedge clk);
			#drive_delay;
			waited++;
		end while (!wb_ack && waited < bus_timeout);
		if (!wb_ack) abort_run("no ack on the Wishbone bus");
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic bus_read(input wb_addr_t adr, output wb_data_t data);
		bus_cycle(1'b0, adr, '0, data);
	endtask

	task automatic bus_write(input wb_addr_t adr, input wb_data_t data);
		wb_data_t unused;
		bus_cycle(1'b1, adr, data, unused);
	endtask

	task automatic send_frame(input rx_byte_t data, input logic bad_parity, input logic bad_stop);
		logic [frame_bits-1:0] bits;
		bits = {!bad_stop, (^data) ^ bad_parity, data, 1'b0}; // Start bit goes first.
		for (int i = 0; i < frame_bits; i++) begin
			serial_in = bits[i];
			repeat (clocks_per_bit) @(posedge clk);
			#drive_delay;
		end
		serial_in = 1'b1;
	endtask

	task automatic idle_bits(input int bits);
		serial_in = 1'b1;
		repeat (bits * clocks_per_bit) @(posedge clk);
		#drive_delay;
	endtask

	// Polls until the frame has landed.
	task automatic wait_for_status(input wb_data_t expected);
		wb_data_t status;
		int polls;
		polls = 0;
		bus_read(addr_status, status);
		while (status !== expected && polls < status_polls) begin
			bus_read(addr_status, status);
			polls++;
		end
		check_word(status, expected, "status after frame");
	endtask

	task automatic drain_fifo();
		rx_byte_t expected;
		wb_data_t word;
		while (expected_bytes.size() > 0) begin
			expected = expected_bytes.pop_front();
			bus_read(addr_rx_data, word);
			check_byte(rx_byte_t'(word[7:0]), expected, "received byte");
		end
		bus_read(addr_status, word);
		check_word(word, expected_status(), "status after drain");
	endtask

	initial begin
		frame_entry_t entry;
		rx_byte_t data;
		wb_data_t word;
		int waited;
		int assert_errors;

		serial_in = 1'b1; // Line idles high.
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		byte_errors = 0;
		word_errors = 0;
		rng_state = 32'd94792;
		model_parity = '0;
		model_frame = '0;
		model_overrun = 1'b0;

		waited = 0;
		@(posedge clk);
		while (reset && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if (reset) abort_run("reset was never released");
		#drive_delay;
		idle_bits(1);

		foreach (frame_table[i]) begin
			entry = frame_table[i];
			data = entry.data;
			if (entry.random_data) begin
				rng_state = next_random(rng_state);
				data = rng_state[7:0];
			end
			send_frame(data, entry.bad_parity, entry.bad_stop);
			record_frame(data, entry.bad_parity, entry.bad_stop);
			if (entry.read_back) begin
				wait_for_status(expected_status());
				drain_fifo();
				idle_bits(2);
			end
		end

		// Glitch shorter than half a bit.
		serial_in = 1'b0;
		repeat (half_bit / 2) @(posedge clk);
		#drive_delay;
		idle_bits(14); // Longer than the guard period.
		bus_read(addr_status, word);
		check_word(word, expected_status(), "status after glitch");

		bus_write(addr_control, 32'h1);
		model_parity = '0;
		model_frame = '0;
		model_overrun = 1'b0;
		bus_read(addr_status, word);
		check_word(word, expected_status(), "status after clear");
		bus_read(addr_rx_data, word);
		check_word(word, '0, "data read from empty FIFO");

		assert_errors = uart_rx_top_i.detect_start_bit_i.start_props_i.failures
			+ uart_rx_top_i.wb_uart_regs_i.bus_props_i.failures;
		$display("Errors: %0d byte mismatches, %0d word mismatches, %0d assertion failures",
			byte_errors, word_errors, assert_errors);
		if (byte_errors == 0 && word_errors == 0 && assert_errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* verif/uart_rx_props.sv */
`timescale 1ns/100ps

module uart_rx_props (
	input logic clk,
	input logic reset,
	input logic start_detected,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack
);

	int failures = 0;

	start_single: assert property (@(posedge clk) disable iff (reset)
		start_detected |=> !start_detected)
		else begin
			failures++;
			$error("start_detected high on two cycles in a row");
		end

	// Ack follows a request seen one clock earlier.
	ack_needs_request: assert property (@(posedge clk) disable iff (reset)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else begin
			failures++;
			$error("wb_ack rose without cyc and stb");
		end

	ack_single: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else begin
			failures++;
			$error("wb_ack high for two cycles");
		end

	reset_quiet: assert property (@(posedge clk)
		reset |=> !wb_ack && !start_detected)
		else begin
			failures++;
			$error("wb_ack or start_detected high after reset");
		end

endmodule

// Bus inputs tied off on the detector side.
bind detect_start_bit uart_rx_props start_props_i (
	.clk, .reset, .start_detected,
	.wb_cyc(1'b0), .wb_stb(1'b0), .wb_ack(1'b0)
);

bind wb_uart_regs uart_rx_props bus_props_i (
	.clk, .reset, .start_detected(1'b0),
	.wb_cyc, .wb_stb, .wb_ack
);

/* verif/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period.
	end

	// Released shortly after the fifth rising edge.
	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#10 reset = 1'b0;
	end

endmodule

/* hdl/uart_rx_top.sv */
`timescale 1ns/100ps

module uart_rx_top #(
	parameter int fifo_depth = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic serial_in,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  wb_regs_pkg::wb_addr_t wb_adr,
	input  wb_regs_pkg::wb_data_t wb_dat_w,
	output wb_regs_pkg::wb_data_t wb_dat_r,
	output logic wb_ack
);
	import uart_frame_pkg::*;

	logic serial_synced;
	logic start_detected;
	rx_byte_t frame_data;
	logic frame_valid;
	logic parity_error;
	logic framing_error;
	rx_byte_t fifo_data;
	logic fifo_empty;
	logic [$clog2(fifo_depth+1)-1:0] fifo_count;
	logic overrun;
	logic fifo_pop;
	logic clear_overrun;

	detect_start_bit detect_start_bit_i (
		.clk, .reset, .serial_in, .serial_synced, .start_detected
	);

	rx_frame_sampler rx_frame_sampler_i (
		.clk, .reset, .serial_synced, .start_detected,
		.frame_data, .frame_valid, .parity_error, .framing_error
	);

	// Only good frames are pushed.
	rx_fifo #(.fifo_depth(fifo_depth)) rx_fifo_i (
		.clk, .reset,
		.push(frame_valid), .push_data(frame_data),
		.pop(fifo_pop), .clear_overrun,
		.pop_data(fifo_data), .empty(fifo_empty), .count(fifo_count), .overrun
	);

	wb_uart_regs #(.fifo_depth(fifo_depth)) wb_uart_regs_i (
		.clk, .reset,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.fifo_data, .fifo_empty, .fifo_count, .overrun,
		.parity_error, .framing_error, .fifo_pop, .clear_overrun
	);

endmodule

/* hdl/wb_uart_regs.sv */
`timescale 1ns/100ps

module wb_uart_regs #(
	parameter int fifo_depth = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  wb_regs_pkg::wb_addr_t wb_adr,
	input  wb_regs_pkg::wb_data_t wb_dat_w,
	output wb_regs_pkg::wb_data_t wb_dat_r,
	output logic wb_ack,
	input  uart_frame_pkg::rx_byte_t fifo_data,
	input  logic fifo_empty,
	input  logic [$clog2(fifo_depth+1)-1:0] fifo_count,
	input  logic overrun,
	input  logic parity_error,
	input  logic framing_error,
	output logic fifo_pop,
	output logic clear_overrun
);
	import wb_regs_pkg::*;

	logic bus_req; // New cycle, not yet acked.
	logic rd_req;
	logic wr_req;
	logic clear_counts;
	err_count_t parity_count;
	err_count_t frame_count;
	wb_data_t status_word;
	wb_data_t read_mux;

	assign bus_req = wb_cyc && wb_stb && !wb_ack;
	assign rd_req = bus_req && !wb_we;
	assign wr_req = bus_req && wb_we;

	// Effects land on the edge where ack rises.
	assign fifo_pop = rd_req && (wb_adr == addr_rx_data) && !fifo_empty;
	assign clear_counts = wr_req && (wb_adr == addr_control) && wb_dat_w[0];
	assign clear_overrun = clear_counts;

	always_comb begin
		status_word = '0;
		status_word[status_empty_bit] = fifo_empty;
		status_word[status_overrun_bit] = overrun;
		// Count field is as wide as an error counter.
		status_word[status_count_lsb +: $bits(err_count_t)] = err_count_t'(fifo_count);
		status_word[status_parity_lsb +: $bits(err_count_t)] = parity_count;
		status_word[status_frame_lsb +: $bits(err_count_t)] = frame_count;
	end

	always_comb begin
		case (wb_adr)
			addr_rx_data: read_mux = fifo_empty ? '0 : wb_data_t'(fifo_data);
			addr_status: read_mux = status_word;
			default: read_mux = '0; // Control reads back as zero.
		endcase
	end

	// Single cycle ack, no wait states.
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack <= 1'b0;
		end else begin
			wb_ack <= bus_req;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_req) wb_dat_r <= read_mux;
	end

	// Error counters stick at 255.
	always_ff @(posedge clk) begin
		if (reset || clear_counts) begin
			parity_count <= '0;
			frame_count <= '0;
		end else begin
			if (parity_error && !(&parity_count)) parity_count <= parity_count + 1'b1;
			if (framing_error && !(&frame_count)) frame_count <= frame_count + 1'b1;
		end
	end

endmodule

/* hdl/rx_fifo.sv */
`timescale 1ns/100ps

module rx_fifo #(
	parameter int fifo_depth = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  uart_frame_pkg::rx_byte_t push_data,
	input  logic pop,
	input  logic clear_overrun,
	output uart_frame_pkg::rx_byte_t pop_data,
	output logic empty,
	output logic [$clog2(fifo_depth+1)-1:0] count,
	output logic overrun
);
	import uart_frame_pkg::*;

	localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;

	rx_byte_t mem [fifo_depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	// Wraps at depth, so any depth works.
	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
		if (ptr == ptr_w'(fifo_depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full = (count == fifo_depth);
	assign empty = (count == '0);
	assign do_push = push && !full;
	assign do_pop = pop && !empty; // Pop on empty is ignored.
	assign pop_data = mem[rd_ptr]; // First word falls through.

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overrun <= 1'b0;
		end else begin
			if (do_push) wr_ptr <= next_ptr(wr_ptr);
			if (do_pop) rd_ptr <= next_ptr(rd_ptr);
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// Sticky. A new overrun beats a clear on the same edge.
			if (push && full) begin
				overrun <= 1'b1;
			end else if (clear_overrun) begin
				overrun <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) mem[wr_ptr] <= push_data;
	end

endmodule

/* uart_rx/rx_frame_sampler.sv */
`timescale 1ns/100ps

module rx_frame_sampler (
	input  logic clk,
	input  logic reset,
	input  logic serial_synced,
	input  logic start_detected,
	output uart_frame_pkg::rx_byte_t frame_data,
	output logic frame_valid,
	output logic parity_error,
	output logic framing_error
);
	import uart_frame_pkg::*;

	rx_state_t state;
	baud_count_t baud_count;
	bit_index_t bit_index;
	logic parity_acc; // Running XOR of data and parity bits.
	logic bit_tick;
	logic mid_start;

	assign bit_tick = (baud_count == baud_count_t'(clocks_per_bit - 1));
	assign mid_start = (baud_count == baud_count_t'(half_bit - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RX_IDLE;
			baud_count <= '0;
			bit_index <= '0;
			parity_acc <= 1'b0;
			frame_valid <= 1'b0;
			parity_error <= 1'b0;
			framing_error <= 1'b0;
		end else begin
			// Result pulses last one clock.
			frame_valid <= 1'b0;
			parity_error <= 1'b0;
			framing_error <= 1'b0;

			case (state)
				RX_IDLE: begin
					if (start_detected) begin
						state <= RX_START;
						baud_count <= '0;
						bit_index <= '0;
						parity_acc <= 1'b0;
					end
				end

				RX_START: begin
					if (mid_start) begin
						baud_count <= '0;
						// Line back high means a glitch, not a start bit.
						state <= serial_synced ? RX_IDLE : RX_DATA;
					end else begin
						baud_count <= baud_count + 1'b1;
					end
				end

				RX_DATA: begin
					if (bit_tick) begin
						baud_count <= '0;
						parity_acc <= parity_acc ^ serial_synced;
						bit_index <= bit_index + 1'b1;
						if (bit_index == bit_index_t'(data_bits - 1)) begin
							state <= RX_PARITY;
						end
					end else begin
						baud_count <= baud_count + 1'b1;
					end
				end

				RX_PARITY: begin
					if (bit_tick) begin
						baud_count <= '0;
						parity_acc <= parity_acc ^ serial_synced; // Even parity gives 0.
						state <= RX_STOP;
					end else begin
						baud_count <= baud_count + 1'b1;
					end
				end

				RX_STOP: begin
					if (bit_tick) begin
						baud_count <= '0;
						state <= RX_IDLE;
						if (!serial_synced) begin
							framing_error <= 1'b1; // Takes priority over parity.
						end else if (parity_acc) begin
							parity_error <= 1'b1;
						end else begin
							frame_valid <= 1'b1;
						end
					end else begin
						baud_count <= baud_count + 1'b1;
					end
				end

				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data arrives LSB first.
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_tick) begin
			frame_data <= {serial_synced, frame_data[data_bits-1:1]};
		end
	end

endmodule

/* uart_rx/detect_start_bit.sv */
`timescale 1ns/100ps

module detect_start_bit (
	input  logic clk,
	input  logic reset,
	input  logic serial_in,
	output logic serial_synced,
	output logic start_detected
);
	import uart_frame_pkg::*;

	logic sync_meta;      // First synchronizer stage.
	logic previous_level; // Synced line one clock earlier.
	logic falling_edge;
	logic guard_open;
	guard_count_t guard_count;

	// Two flop synchronizer plus edge history.
	// Line idles high, so everything resets to 1.
	always_ff @(posedge clk) begin
		if (reset) begin
			sync_meta <= 1'b1;
			serial_synced <= 1'b1;
			previous_level <= 1'b1;
		end else begin
			sync_meta <= serial_in;
			serial_synced <= sync_meta;
			previous_level <= serial_synced;
		end
	end

	assign falling_edge = previous_level && !serial_synced;

	// Guard expired, a new frame may start.
	assign guard_open = (guard_count >= guard_count_t'(guard_clocks));

	// Data bits inside a frame make edges too.
	// The guard counter hides them until the frame is nearly over.
	always_ff @(posedge clk) begin
		if (reset) begin
			start_detected <= 1'b0;
			guard_count <= guard_count_t'(guard_clocks); // First edge is accepted.
		end else if (falling_edge && guard_open) begin
			start_detected <= 1'b1;
			guard_count <= '0;
		end else begin
			start_detected <= 1'b0;
			if (!guard_open) begin
				guard_count <= guard_count + 1'b1; // Saturates at guard_clocks.
			end
		end
	end

endmodule

/* common/wb_regs_pkg.sv */
package wb_regs_pkg;

	// Wishbone classic widths.
	typedef logic [1:0] wb_addr_t;  // Word address.
	typedef logic [31:0] wb_data_t;

	// Register map.
	localparam wb_addr_t addr_rx_data = 2'd0; // Read pops the oldest byte.
	localparam wb_addr_t addr_status = 2'd1;  // Read only.
	localparam wb_addr_t addr_control = 2'd2; // Bit 0 clears errors and overrun.

	// Status word layout.
	localparam int status_empty_bit = 0;
	localparam int status_overrun_bit = 1;
	localparam int status_count_lsb = 8;
	localparam int status_parity_lsb = 16;
	localparam int status_frame_lsb = 24;

	// Saturating error counter.
	typedef logic [7:0] err_count_t;

endpackage

/* common/uart_frame_pkg.sv */
package uart_frame_pkg;

	// Fixed frame: start, 8 data, even parity, stop.
	localparam int data_bits = 8;
	localparam int frame_bits = 11;

	// Bit timing in system clocks, kept short for simulation.
	localparam int clocks_per_bit = 16;
	localparam int half_bit = 8; // Start edge to middle of start bit.

	// Ten and a half bit times.
	// Leaves room for the start edge of a back-to-back frame.
	localparam int guard_clocks = 168;

	typedef logic [7:0] rx_byte_t;
	typedef logic [4:0] baud_count_t; // Clocks within one bit.
	typedef logic [2:0] bit_index_t;  // Data bit being sampled.
	typedef logic [7:0] guard_count_t;

	// Frame sampler states.
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_t;

endpackage
